//--- source/gamePkg.sv
/*
 * game types and constants
 * coordinate type, direction and status enums
 * movement keycodes, playfield bounds, start positions
 * pellet table and a distance helper
 */
package gamePkg;

	typedef logic [9:0] coordT; // screen pixel coordinate

	typedef enum logic [2:0] {
		dirNone,
		dirUp,
		dirDown,
		dirLeft,
		dirRight
	} dirT;

	typedef enum logic [1:0] {
		stPlaying,
		stWon,
		stLost
	} statusT;

	// usb hid usage ids
	localparam logic [7:0] KeyW = 8'h1A;
	localparam logic [7:0] KeyA = 8'h04;
	localparam logic [7:0] KeyS = 8'h16;
	localparam logic [7:0] KeyD = 8'h07;

	localparam coordT XMin = 10'd8;
	localparam coordT XMax = 10'd631;
	localparam coordT YMin = 10'd8;
	localparam coordT YMax = 10'd471;

	localparam coordT PacStartX = 10'd320;
	localparam coordT PacStartY = 10'd240;
	localparam coordT GhostStartX = 10'd40; // top left corner of the maze
	localparam coordT GhostStartY = 10'd40;

	localparam int NumPellets = 8;
	localparam coordT PelletX [NumPellets] = '{10'd222, 10'd418, 10'd38, 10'd282,
		10'd282, 10'd354, 10'd102, 10'd530};
	localparam coordT PelletY [NumPellets] = '{10'd32, 10'd32, 10'd78, 10'd78,
		10'd132, 10'd132, 10'd128, 10'd128};

	// unsigned distance between two coordinates
	function automatic coordT absDiff(input coordT a, input coordT b);
		return (a > b) ? a - b : b - a;
	endfunction

endpackage

//--- source/displayPkg.sv
/*
 * seven-segment display definitions
 * segment pattern type and hex digit lookup table
 */
package displayPkg;

	// bit 6 is segment g, bit 0 is segment a, active low
	typedef logic [6:0] segT;

	localparam segT HexSeg [16] = '{
		7'b1000000, // 0
		7'b1111001, // 1
		7'b0100100, // 2
		7'b0110000, // 3
		7'b0011001, // 4
		7'b0010010, // 5
		7'b0000010, // 6
		7'b1111000, // 7
		7'b0000000, // 8
		7'b0010000, // 9
		7'b0001000, // A
		7'b0000011, // b
		7'b1000110, // C
		7'b0100001, // d
		7'b0000110, // E
		7'b0001110  // F
	};

endpackage

//--- source/playfieldIf.sv
/*
 * playfield interface
 * player position, decoded direction and freeze level
 */
`timescale 1ns/1ns

interface playfieldIf import gamePkg::*; ();

	coordT pacX;
	coordT pacY;
	dirT dir;
	logic stop; // high once the game is decided

	modport decoder (output dir);
	modport mover (output pacX, output pacY, input dir, input stop);
	modport judge (output stop);
	modport observer (input pacX, input pacY, input stop);

endinterface

//--- source/keyDecode.sv
/*
 * keycode decoder
 * registers a movement direction from the usb keycode
 */
`timescale 1ns/1ns

module keyDecode import gamePkg::*; (
	input logic frameClk,
	input logic arstN,
	input logic [7:0] keycode,
	playfieldIf.decoder field
);

	dirT keyDir;
	logic keyHit; // keycode is one of the movement keys

	always_comb begin
		keyHit = 1'b1;
		case (keycode)
			KeyW: keyDir = dirUp;
			KeyS: keyDir = dirDown;
			KeyA: keyDir = dirLeft;
			KeyD: keyDir = dirRight;
			default: begin
				keyDir = dirNone;
				keyHit = 1'b0;
			end
		endcase
	end

	// a released key reads as zero, so the last direction stays
	always_ff @(posedge frameClk or negedge arstN) begin
		if (!arstN) begin
			field.dir <= dirNone;
		end else if (keyHit) begin
			field.dir <= keyDir;
		end
	end

endmodule

//--- source/pacMotion.sv
/*
 * player motion
 * one step per frame in the decoded direction
 * position clamped to the playfield bounds
 */
`timescale 1ns/1ns

module pacMotion import gamePkg::*; #(
	parameter int PacStep = 2
) (
	input logic frameClk,
	input logic arstN,
	playfieldIf.mover field
);

	localparam logic signed [11:0] Step = 12'(PacStep);

	logic signed [11:0] wideX; // room for sign and overflow
	logic signed [11:0] wideY;
	coordT nextX;
	coordT nextY;

	function automatic coordT clampTo(input logic signed [11:0] v, input coordT lo,
		input coordT hi);
		if (v < $signed({2'b00, lo})) begin
			return lo;
		end
		if (v > $signed({2'b00, hi})) begin
			return hi;
		end
		return v[9:0];
	endfunction

	always_comb begin
		wideX = $signed({2'b00, field.pacX});
		wideY = $signed({2'b00, field.pacY});
		case (field.dir)
			dirUp: wideY = wideY - Step; // screen y grows downward
			dirDown: wideY = wideY + Step;
			dirLeft: wideX = wideX - Step;
			dirRight: wideX = wideX + Step;
			default: ;
		endcase
		nextX = clampTo(wideX, XMin, XMax);
		nextY = clampTo(wideY, YMin, YMax);
	end

	always_ff @(posedge frameClk or negedge arstN) begin
		if (!arstN) begin
			field.pacX <= PacStartX;
			field.pacY <= PacStartY;
		end else if (!field.stop) begin
			field.pacX <= nextX;
			field.pacY <= nextY;
		end
	end

	pacInBounds: assert property (@(posedge frameClk) disable iff (!arstN)
		field.pacX >= XMin && field.pacX <= XMax && field.pacY >= YMin && field.pacY <= YMax);

endmodule

//--- source/ghostChase.sv
/*
 * chasing ghost
 * pacing counter, x-first pursuit of the player
 * registered contact flag
 */
`timescale 1ns/1ns

module ghostChase import gamePkg::*; #(
	parameter int GhostStep = 2,
	parameter int GhostPeriod = 4,
	parameter int HitRadius = 8
) (
	input logic frameClk,
	input logic arstN,
	playfieldIf.observer field,
	output logic collide
);

	localparam int CntW = (GhostPeriod > 1) ? $clog2(GhostPeriod) : 1;
	localparam logic [CntW-1:0] CntLast = CntW'(GhostPeriod - 1);
	localparam coordT Step = coordT'(GhostStep);
	localparam coordT Radius = coordT'(HitRadius);

	coordT ghostX;
	coordT ghostY;
	coordT distX;
	coordT distY;
	coordT moveX;
	coordT moveY;
	logic [CntW-1:0] paceCnt;
	logic moveNow;

	assign distX = absDiff(ghostX, field.pacX);
	assign distY = absDiff(ghostY, field.pacY);
	assign moveX = (distX < Step) ? distX : Step; // never overshoot
	assign moveY = (distY < Step) ? distY : Step;
	assign moveNow = (paceCnt == CntLast) && !field.stop;

	// ============================
	// pacing
	always_ff @(posedge frameClk or negedge arstN) begin
		if (!arstN) begin
			paceCnt <= '0;
		end else if (!field.stop) begin
			paceCnt <= (paceCnt == CntLast) ? '0 : paceCnt + 1'b1;
		end
	end

	// ============================
	// pursuit closes x before y
	always_ff @(posedge frameClk or negedge arstN) begin
		if (!arstN) begin
			ghostX <= GhostStartX;
			ghostY <= GhostStartY;
		end else if (moveNow) begin
			if (distX != '0) begin
				ghostX <= (field.pacX > ghostX) ? ghostX + moveX : ghostX - moveX;
			end else begin
				ghostY <= (field.pacY > ghostY) ? ghostY + moveY : ghostY - moveY;
			end
		end
	end

	always_ff @(posedge frameClk or negedge arstN) begin
		if (!arstN) begin
			collide <= 1'b0;
		end else begin
			collide <= (distX < Radius) && (distY < Radius); // box overlap
		end
	end

	paceInRange: assert property (@(posedge frameClk) disable iff (!arstN)
		paceCnt < GhostPeriod);

endmodule

//--- source/pelletTracker.sv
/*
 * pellet tracker
 * compares the player against the pellet table
 * sticky eaten flag per pellet
 */
`timescale 1ns/1ns

module pelletTracker import gamePkg::*; #(
	parameter int HitRadius = 8
) (
	input logic frameClk,
	input logic arstN,
	playfieldIf.observer field,
	output logic [NumPellets-1:0] eaten
);

	localparam coordT Radius = coordT'(HitRadius);

	logic [NumPellets-1:0] touch; // player over pellet this frame

	always_comb begin
		for (int i = 0; i < NumPellets; i++) begin
			touch[i] = (absDiff(field.pacX, PelletX[i]) < Radius) &&
				(absDiff(field.pacY, PelletY[i]) < Radius);
		end
	end

	// once eaten, a pellet stays gone
	always_ff @(posedge frameClk or negedge arstN) begin
		if (!arstN) begin
			eaten <= '0;
		end else begin
			eaten <= eaten | touch;
		end
	end

endmodule

//--- source/gameStatus.sv
/*
 * game status
 * playing, won and lost state register
 * win, lose and freeze decode
 */
`timescale 1ns/1ns

module gameStatus import gamePkg::*; (
	input logic frameClk,
	input logic arstN,
	input logic collide,
	input logic [NumPellets-1:0] eaten,
	playfieldIf.judge field,
	output logic win,
	output logic lose
);

	statusT state;
	statusT stateNext;

	always_comb begin
		stateNext = state;
		if (state == stPlaying) begin
			if (&eaten) stateNext = stWon; // clearing the board beats a late hit
			else if (collide) stateNext = stLost;
		end
	end

	always_ff @(posedge frameClk or negedge arstN) begin
		if (!arstN) state <= stPlaying;
		else state <= stateNext;
	end

	assign field.stop = (state != stPlaying);
	assign win = (state == stWon);
	assign lose = (state == stLost);

	resultHeld: assert property (@(posedge frameClk) disable iff (!arstN)
		state != stPlaying |=> $stable(state));

endmodule

//--- source/positionHex.sv
/*
 * position readout
 * player x and y as six hex digits on seven-segment displays
 */
`timescale 1ns/1ns

module positionHex import displayPkg::*; (
	playfieldIf.observer field,
	output segT hex0,
	output segT hex1,
	output segT hex2,
	output segT hex3,
	output segT hex4,
	output segT hex5
);

	// x on the left group
	assign hex5 = HexSeg[{2'b00, field.pacX[9:8]}]; // top two bits only
	assign hex4 = HexSeg[field.pacX[7:4]];
	assign hex3 = HexSeg[field.pacX[3:0]];

	// y on the right group
	assign hex2 = HexSeg[{2'b00, field.pacY[9:8]}];
	assign hex1 = HexSeg[field.pacY[7:4]];
	assign hex0 = HexSeg[field.pacY[3:0]];

endmodule

//--- source/pacmanTop.sv
/*
 * maze chase game top level
 * keycode in, player position, pellets, result and hex digits out
 */
`timescale 1ns/1ns

module pacmanTop #(
	parameter int PacStep = 2,
	parameter int GhostStep = 2,
	parameter int GhostPeriod = 4,
	parameter int HitRadius = 8
) (
	input logic frameClk,
	input logic arstN,
	input logic [7:0] keycode,
	output logic [9:0] pacX,
	output logic [9:0] pacY,
	output logic [7:0] eaten,
	output logic win,
	output logic lose,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5
);

	playfieldIf field ();
	logic collide; // ghost on player

	assign pacX = field.pacX;
	assign pacY = field.pacY;

	// ============================
	// player
	keyDecode uKeyDecode (.frameClk, .arstN, .keycode, .field(field.decoder));

	pacMotion #(.PacStep(PacStep)) uPacMotion (.frameClk, .arstN, .field(field.mover));

	// ============================
	// opponents and scoring
	ghostChase #(
		.GhostStep(GhostStep),
		.GhostPeriod(GhostPeriod),
		.HitRadius(HitRadius)
	) uGhostChase (.frameClk, .arstN, .field(field.observer), .collide);

	pelletTracker #(.HitRadius(HitRadius)) uPelletTracker (
		.frameClk, .arstN, .field(field.observer), .eaten);

	gameStatus uGameStatus (.frameClk, .arstN, .collide, .eaten, .field(field.judge),
		.win, .lose);

	// ============================
	// display
	positionHex uPositionHex (.field(field.observer), .hex0, .hex1, .hex2, .hex3,
		.hex4, .hex5);

endmodule

//--- tb/pacmanModel.svh
/*
 * reference model of one game frame
 * model state, reset values and per-frame update
 * seven-segment reference pattern
 */
`ifndef PACMAN_MODEL_SVH
`define PACMAN_MODEL_SVH

dirT mDir;
int mPacX;
int mPacY;
int mGhostX;
int mGhostY;
int mCnt; // ghost pacing
logic mCollide;
logic [NumPellets-1:0] mEaten;
statusT mState;

function automatic int absInt(input int v);
	return (v < 0) ? -v : v;
endfunction

function automatic int clampInt(input int v, input int lo, input int hi);
	if (v < lo) return lo;
	if (v > hi) return hi;
	return v;
endfunction

// at most step pixels toward the target without overshoot
function automatic int approach(input int from, input int to, input int step);
	if (to > from) return from + ((to - from < step) ? to - from : step);
	return from - ((from - to < step) ? from - to : step);
endfunction

task automatic modelReset();
	mDir = dirNone;
	mPacX = int'(PacStartX);
	mPacY = int'(PacStartY);
	mGhostX = int'(GhostStartX);
	mGhostY = int'(GhostStartY);
	mCnt = 0;
	mCollide = 1'b0;
	mEaten = '0;
	mState = stPlaying;
endtask

// every term reads the state from before the edge
task automatic modelStep(input logic [7:0] key);
	dirT nDir;
	int nPx;
	int nPy;
	int nGx;
	int nGy;
	int nCnt;
	logic nCollide;
	logic [NumPellets-1:0] nEaten;
	statusT nState;
	logic frozen;
	frozen = (mState != stPlaying);
	nDir = mDir;
	if (key == KeyW) nDir = dirUp;
	else if (key == KeyS) nDir = dirDown;
	else if (key == KeyA) nDir = dirLeft;
	else if (key == KeyD) nDir = dirRight;
	nPx = mPacX;
	nPy = mPacY;
	if (!frozen) begin
		case (mDir)
			dirUp: nPy = mPacY - PacStep;
			dirDown: nPy = mPacY + PacStep;
			dirLeft: nPx = mPacX - PacStep;
			dirRight: nPx = mPacX + PacStep;
			default: ;
		endcase
		nPx = clampInt(nPx, int'(XMin), int'(XMax));
		nPy = clampInt(nPy, int'(YMin), int'(YMax));
	end
	nGx = mGhostX;
	nGy = mGhostY;
	nCnt = mCnt;
	if (!frozen) begin
		if (mCnt == GhostPeriod - 1) begin
			if (mGhostX != mPacX) nGx = approach(mGhostX, mPacX, GhostStep);
			else nGy = approach(mGhostY, mPacY, GhostStep);
			nCnt = 0;
		end else begin
			nCnt = mCnt + 1;
		end
	end
	nCollide = (absInt(mGhostX - mPacX) < HitRadius) && (absInt(mGhostY - mPacY) < HitRadius);
	nEaten = mEaten;
	for (int i = 0; i < NumPellets; i++) begin
		if (absInt(mPacX - int'(PelletX[i])) < HitRadius &&
			absInt(mPacY - int'(PelletY[i])) < HitRadius) nEaten[i] = 1'b1;
	end
	nState = mState;
	if (mState == stPlaying) begin
		if (&mEaten) nState = stWon; // a full board wins over a hit
		else if (mCollide) nState = stLost;
	end
	mDir = nDir;
	mPacX = nPx;
	mPacY = nPy;
	mGhostX = nGx;
	mGhostY = nGy;
	mCnt = nCnt;
	mCollide = nCollide;
	mEaten = nEaten;
	mState = nState;
endtask

// active low pattern with bit 6 as segment g
function automatic segT segRef(input logic [3:0] digit);
	logic [6:0] lit; // lit segments in gfedcba order
	case (digit)
		4'h0: lit = 7'h3F;
		4'h1: lit = 7'h06;
		4'h2: lit = 7'h5B;
		4'h3: lit = 7'h4F;
		4'h4: lit = 7'h66;
		4'h5: lit = 7'h6D;
		4'h6: lit = 7'h7D;
		4'h7: lit = 7'h07;
		4'h8: lit = 7'h7F;
		4'h9: lit = 7'h6F;
		4'hA: lit = 7'h77;
		4'hB: lit = 7'h7C;
		4'hC: lit = 7'h39;
		4'hD: lit = 7'h5E;
		4'hE: lit = 7'h79;
		default: lit = 7'h71;
	endcase
	return ~lit;
endfunction

`endif

//--- tb/pacmanTb.sv
/*
 * testbench for the maze chase game
 * clock, reset, key stimulus, model compare
 * typed compare tasks, timeout and final report
 */
`timescale 1ns/1ns

module pacmanTb import gamePkg::*, displayPkg::*; ();

	localparam int PacStep = 2;
	localparam int GhostStep = 2;
	localparam int GhostPeriod = 6; // slower than the default ghost
	localparam int HitRadius = 8;

	localparam int ResetLen = 10;
	localparam int SteerLen = 330; // 10 + 5 + 5 + 130 + 180
	localparam int PelletLen = 211;
	localparam int CatchWait = 1000;
	localparam int CatchLen = 280 + CatchWait + 20;
	localparam int RandomLen = 600;
	localparam int CycleLimit = 4 * ResetLen + SteerLen + PelletLen + CatchLen + RandomLen + 50;

	logic frameClk;
	logic arstN;
	logic [7:0] keycode;
	logic [9:0] pacX;
	logic [9:0] pacY;
	logic [7:0] eaten;
	logic win;
	logic lose;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;
	logic [6:0] hex3;
	logic [6:0] hex4;
	logic [6:0] hex5;

	int seed = 84;
	int cycleCount = 0;
	int checkCount = 0;
	int valueErrs = 0;
	int otherErrs = 0;
	string testName = "reset";

	`include "pacmanModel.svh"

	pacmanTop #(
		.PacStep(PacStep),
		.GhostStep(GhostStep),
		.GhostPeriod(GhostPeriod),
		.HitRadius(HitRadius)
	) u_dut (.frameClk, .arstN, .keycode, .pacX, .pacY, .eaten, .win, .lose,
		.hex0, .hex1, .hex2, .hex3, .hex4, .hex5);

	initial begin
		frameClk = 1'b0;
		forever #50 frameClk = ~frameClk;
	end

	// ============================
	// compare tasks
	task automatic checkCoord(input string name, input coordT expected, input coordT actual);
		checkCount++;
		if (actual !== expected) begin
			valueErrs++;
			$display("[ERROR] %s %s expected %0d actual %0d", testName, name, expected, actual);
		end
	endtask

	task automatic checkEaten(input string name, input logic [NumPellets-1:0] expected,
		input logic [NumPellets-1:0] actual);
		checkCount++;
		if (actual !== expected) begin
			valueErrs++;
			$display("[ERROR] %s %s expected %b actual %b", testName, name, expected, actual);
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			valueErrs++;
			$display("[ERROR] %s %s expected %b actual %b", testName, name, expected, actual);
		end
	endtask

	task automatic checkSeg(input string name, input segT expected, input segT actual);
		checkCount++;
		if (actual !== expected) begin
			valueErrs++;
			$display("[ERROR] %s %s expected %b actual %b", testName, name, expected, actual);
		end
	endtask

	// ============================
	// model and checker
	always @(posedge frameClk or negedge arstN) begin
		if (!arstN) modelReset();
		else modelStep(keycode);
	end

	always @(negedge frameClk) begin
		coordT expX;
		coordT expY;
		expX = coordT'(mPacX);
		expY = coordT'(mPacY);
		if (arstN) begin
			checkCoord("pacX", expX, pacX);
			checkCoord("pacY", expY, pacY);
			checkEaten("eaten", mEaten, eaten);
			checkFlag("win", mState == stWon, win);
			checkFlag("lose", mState == stLost, lose);
			checkSeg("hex5", segRef({2'b00, expX[9:8]}), hex5);
			checkSeg("hex4", segRef(expX[7:4]), hex4);
			checkSeg("hex3", segRef(expX[3:0]), hex3);
			checkSeg("hex2", segRef({2'b00, expY[9:8]}), hex2);
			checkSeg("hex1", segRef(expY[7:4]), hex1);
			checkSeg("hex0", segRef(expY[3:0]), hex0);
		end
	end

	always @(posedge frameClk) begin
		cycleCount++;
		if (cycleCount >= CycleLimit) begin
			$display("timeout after %0d cycles, the stimulus never finished", cycleCount);
			$display("Verification failed");
			$finish;
		end
	end

	// ============================
	// stimulus helpers
	task automatic applyReset();
		keycode = 8'h00;
		arstN = 1'b0;
		repeat (ResetLen) @(negedge frameClk);
		arstN = 1'b1;
	endtask

	task automatic holdKey(input logic [7:0] key, input int frames);
		keycode = key;
		repeat (frames) @(negedge frameClk);
	endtask

	initial begin
		coordT x0;
		coordT holdX;
		coordT holdY;
		int pick;
		int burst;
		int done;
		int waited;
		logic [7:0] key;
		keycode = 8'h00;
		arstN = 1'b0;
		applyReset();
		checkCoord("startX", PacStartX, pacX);
		checkCoord("startY", PacStartY, pacY);
		checkEaten("startEaten", '0, eaten);
		checkFlag("startWin", 1'b0, win);
		checkFlag("startLose", 1'b0, lose);
		checkSeg("startHex5", segRef({2'b00, PacStartX[9:8]}), hex5);
		checkSeg("startHex4", segRef(PacStartX[7:4]), hex4);
		checkSeg("startHex3", segRef(PacStartX[3:0]), hex3);
		checkSeg("startHex2", segRef({2'b00, PacStartY[9:8]}), hex2);
		checkSeg("startHex1", segRef(PacStartY[7:4]), hex1);
		checkSeg("startHex0", segRef(PacStartY[3:0]), hex0);

		// key registers on one edge and moves the player on the next
		testName = "steer";
		keycode = KeyD;
		x0 = pacX;
		@(negedge frameClk);
		checkCoord("firstEdge", x0, pacX);
		@(negedge frameClk);
		checkCoord("secondEdge", x0 + coordT'(PacStep), pacX);
		holdKey(KeyD, 8);
		holdKey(8'h00, 5); // released key
		holdKey(8'h55, 5); // not a movement key
		holdKey(KeyW, 130);
		holdKey(KeyA, 180);
		checkCoord("clampLeft", XMin, pacX);
		checkCoord("clampTop", YMin, pacY);

		// path over pellets 4, 3 and 1
		testName = "pellets";
		applyReset();
		holdKey(KeyW, 54);
		holdKey(KeyA, 19);
		holdKey(KeyW, 50);
		holdKey(KeyD, 68);
		holdKey(8'h00, 20);
		checkEaten("visited", 8'b0001_1010, eaten);

		// park in the top left corner and let the ghost come
		testName = "catch";
		applyReset();
		holdKey(KeyW, 120);
		holdKey(KeyA, 160);
		waited = 0;
		while (!lose && waited < CatchWait) begin
			@(negedge frameClk);
			waited++;
		end
		if (!lose) begin
			otherErrs++;
			$display("the ghost did not catch the parked player in %0d cycles", CatchWait);
		end
		holdX = pacX;
		holdY = pacY;
		holdKey(KeyD, 20);
		checkCoord("frozenX", holdX, pacX);
		checkCoord("frozenY", holdY, pacY);
		checkFlag("noWin", 1'b0, win);

		testName = "random";
		applyReset();
		done = 0;
		while (done < RandomLen) begin
			pick = $unsigned($random(seed)) % 6;
			burst = 1 + $unsigned($random(seed)) % 40;
			if (burst > RandomLen - done) burst = RandomLen - done;
			case (pick)
				0: key = KeyW;
				1: key = KeyA;
				2: key = KeyS;
				3: key = KeyD;
				4: key = 8'h00;
				default: key = 8'($random(seed));
			endcase
			holdKey(key, burst);
			done += burst;
		end

		@(posedge frameClk);
		$display("checks %0d, value errors %0d, other errors %0d", checkCount, valueErrs,
			otherErrs);
		if (valueErrs == 0 && otherErrs == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- pacmanTop.f
+incdir+tb
source/gamePkg.sv
source/displayPkg.sv
source/playfieldIf.sv
source/keyDecode.sv
source/pacMotion.sv
source/ghostChase.sv
source/pelletTracker.sv
source/gameStatus.sv
source/positionHex.sv
source/pacmanTop.sv
tb/pacmanTb.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
verilator --binary --timing --assert -Wno-fatal --top-module pacmanTb -f pacmanTop.f \
	--Mdir obj_dir -o pacmanSim > build.log 2>&1 &&
	./obj_dir/pacmanSim > sim.log 2>&1 ||
	{ echo "build or run error, see build.log and sim.log"; exit 1; }
grep -qx "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
